// ==== logic/eci_rd_pkg.sv ====
`default_nettype none

package eci_rd_pkg;

    // Bus and message widths
    localparam int ECI_ID_WIDTH      = 5;
    localparam int ECI_ADDR_WIDTH    = 40;
    localparam int ECI_WORD_WIDTH    = 64;
    localparam int ECI_SIZE_WIDTH    = 5;

    // Cache line geometry
    localparam int ECI_CL_SIZE_BYTES = 128;
    localparam int ECI_CL_WORDS      = ECI_CL_SIZE_BYTES / (ECI_WORD_WIDTH / 8);
    localparam int ECI_ADDR_LSB      = $clog2(ECI_CL_SIZE_BYTES);

    // Beat counter for one line on the R channel
    localparam int ECI_BEAT_CNT_WIDTH = $clog2(ECI_CL_WORDS);
    localparam logic [ECI_BEAT_CNT_WIDTH-1:0] ECI_LAST_BEAT =
        ECI_BEAT_CNT_WIDTH'(ECI_CL_WORDS - 1);

    // Line index bits folded with the bits just above them
    localparam int ECI_ALIAS_BITS    = 7;

    // Word counts carried in the VC size field
    localparam logic [ECI_SIZE_WIDTH-1:0] ECI_RLDT_SIZE = ECI_SIZE_WIDTH'(1);
    localparam logic [ECI_SIZE_WIDTH-1:0] ECI_NACK_SIZE = ECI_SIZE_WIDTH'(1);
    localparam logic [ECI_SIZE_WIDTH-1:0] ECI_PSHA_SIZE = ECI_SIZE_WIDTH'(ECI_CL_WORDS + 1);

    // Opcodes used on the read path
    typedef enum logic [4:0] {
        ECI_CMD_MREQ_RLDT = 5'b00000,
        ECI_CMD_VRSP_NACK = 5'b01011,
        ECI_CMD_VRSP_PSHA = 5'b01100
    } eci_opcode_t;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_SLVERR = 2'b10
    } axi_resp_t;

    // Load request word, MSB first; response headers share the top fields
    typedef struct packed {
        eci_opcode_t                opcode;
        logic [ECI_ID_WIDTH-1:0]    rreq_id;
        logic [3:0]                 dmask;
        logic                       ns;
        logic [8:0]                 rsvd;
        logic [ECI_ADDR_WIDTH-1:0]  address;
    } eci_rldt_t;

    // XOR the line index with the next bits up to spread lines over sets
    function automatic logic [ECI_ADDR_WIDTH-1:0] eci_alias_address(
        input logic [ECI_ADDR_WIDTH-1:0] addr
    );
        logic [ECI_ADDR_WIDTH-1:0] aliased;

        aliased = addr;
        aliased[ECI_ADDR_LSB +: ECI_ALIAS_BITS] =
            addr[ECI_ADDR_LSB +: ECI_ALIAS_BITS] ^
            addr[ECI_ADDR_LSB + ECI_ALIAS_BITS +: ECI_ALIAS_BITS];
        return aliased;
    endfunction

endpackage

`default_nettype wire

// ==== logic/axi_eci_rd_req.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_eci_rd_req (
    input  logic                                    aclk,
    input  logic                                    aresetn,
    // AXI read address channel
    input  logic [eci_rd_pkg::ECI_ID_WIDTH-1:0]     s_axi_arid,
    input  logic [eci_rd_pkg::ECI_ADDR_WIDTH-1:0]   s_axi_araddr,
    input  logic                                    s_axi_arvalid,
    output logic                                    s_axi_arready,
    // Outgoing request VC towards the CPU
    output logic [eci_rd_pkg::ECI_WORD_WIDTH-1:0]   req_vc_data,
    output logic [eci_rd_pkg::ECI_SIZE_WIDTH-1:0]   req_vc_size,
    output logic                                    req_vc_valid,
    input  logic                                    req_vc_ready
);

    import eci_rd_pkg::*;

    logic                       advance;

    // Stage 0
    logic [ECI_ID_WIDTH-1:0]    arid_q;
    logic [ECI_ADDR_WIDTH-1:0]  araddr_q;
    logic                       arvalid_q;

    // Stage 1
    eci_rldt_t                  rldt_word;
    logic [ECI_WORD_WIDTH-1:0]  req_data_q;
    logic                       req_valid_q;

    // Whole pipeline freezes while the channel is busy
    assign advance       = req_vc_ready;
    assign s_axi_arready = advance;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arvalid_q   <= 1'b0;
            req_valid_q <= 1'b0;
        end else if (advance) begin
            arvalid_q   <= s_axi_arvalid;
            req_valid_q <= arvalid_q;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            arid_q     <= s_axi_arid;
            araddr_q   <= s_axi_araddr;
            req_data_q <= rldt_word;
        end
    end

    // Build the RLDT word from stage 0
    always_comb begin : build_rldt
        logic [ECI_ADDR_WIDTH-1:0] addr_aliased;

        addr_aliased      = eci_alias_address(araddr_q);
        rldt_word         = '0;
        rldt_word.opcode  = ECI_CMD_MREQ_RLDT;
        rldt_word.rreq_id = arid_q;
        rldt_word.dmask   = '1;
        rldt_word.ns      = 1'b1;
        // Line aligned, offset bits dropped
        rldt_word.address = {addr_aliased[ECI_ADDR_WIDTH-1:ECI_ADDR_LSB],
                             {ECI_ADDR_LSB{1'b0}}};
    end

    assign req_vc_data  = req_data_q;
    assign req_vc_size  = ECI_RLDT_SIZE;
    assign req_vc_valid = req_valid_q;

endmodule

`default_nettype wire

// ==== logic/axi_eci_rd_rsp.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_eci_rd_rsp (
    input  logic                                    aclk,
    input  logic                                    aresetn,
    // Incoming response VC from the CPU
    input  logic [eci_rd_pkg::ECI_WORD_WIDTH-1:0]   rsp_vc_data,
    input  logic [eci_rd_pkg::ECI_SIZE_WIDTH-1:0]   rsp_vc_size,
    input  logic                                    rsp_vc_valid,
    output logic                                    rsp_vc_ready,
    // AXI read data channel
    output logic [eci_rd_pkg::ECI_ID_WIDTH-1:0]     m_axi_rid,
    output logic [eci_rd_pkg::ECI_WORD_WIDTH-1:0]   m_axi_rdata,
    output eci_rd_pkg::axi_resp_t                   m_axi_rresp,
    output logic                                    m_axi_rlast,
    output logic                                    m_axi_rvalid,
    input  logic                                    m_axi_rready
);

    import eci_rd_pkg::*;

    typedef enum logic [1:0] {
        RSP_IDLE,
        RSP_DATA,
        RSP_NACK
    } rsp_state_t;

    rsp_state_t                     state;
    logic [ECI_BEAT_CNT_WIDTH-1:0]  beat_cnt;
    logic [ECI_ID_WIDTH-1:0]        rid_q;

    eci_rldt_t                      hdr;
    logic                           hdr_fire;
    logic                           hdr_is_psha;
    logic                           hdr_is_nack;
    logic                           beat_fire;
    logic                           last_beat;

    // Header view of the incoming word
    assign hdr      = eci_rldt_t'(rsp_vc_data);
    assign hdr_fire = (state == RSP_IDLE) && rsp_vc_valid;

    assign hdr_is_psha = (hdr.opcode == ECI_CMD_VRSP_PSHA) &&
                         (rsp_vc_size == ECI_PSHA_SIZE);
    assign hdr_is_nack = (hdr.opcode == ECI_CMD_VRSP_NACK) &&
                         (rsp_vc_size == ECI_NACK_SIZE);

    assign beat_fire = m_axi_rvalid && m_axi_rready;
    assign last_beat = (beat_cnt == ECI_LAST_BEAT);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state    <= RSP_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                RSP_IDLE: begin
                    if (hdr_fire) begin
                        beat_cnt <= '0;
                        // Anything unrecognised is simply consumed
                        if (hdr_is_psha) begin
                            state <= RSP_DATA;
                        end else if (hdr_is_nack) begin
                            state <= RSP_NACK;
                        end
                    end
                end
                RSP_DATA, RSP_NACK: begin
                    if (beat_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= RSP_IDLE;
                        end
                    end
                end
                default: begin
                    state <= RSP_IDLE;
                end
            endcase
        end
    end

    // ID of the burst in progress
    always_ff @(posedge aclk) begin
        if (hdr_fire) begin
            rid_q <= hdr.rreq_id;
        end
    end

    always_comb begin
        rsp_vc_ready = 1'b0;
        m_axi_rvalid = 1'b0;
        m_axi_rdata  = '0;
        m_axi_rresp  = AXI_RESP_OKAY;
        case (state)
            RSP_IDLE: begin
                rsp_vc_ready = 1'b1;
            end
            RSP_DATA: begin
                // Data words flow straight through to R
                rsp_vc_ready = m_axi_rready;
                m_axi_rvalid = rsp_vc_valid;
                m_axi_rdata  = rsp_vc_data;
            end
            RSP_NACK: begin
                // Locally generated error burst, VC stays blocked
                m_axi_rvalid = 1'b1;
                m_axi_rresp  = AXI_RESP_SLVERR;
            end
            default: begin
                rsp_vc_ready = 1'b0;
            end
        endcase
    end

    assign m_axi_rid   = rid_q;
    assign m_axi_rlast = m_axi_rvalid && last_beat;

endmodule

`default_nettype wire

// ==== logic/axi_eci_rd_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_eci_rd_bridge (
    input  logic                                    aclk,
    input  logic                                    aresetn,
    // AXI read address channel
    input  logic [eci_rd_pkg::ECI_ID_WIDTH-1:0]     s_axi_arid,
    input  logic [eci_rd_pkg::ECI_ADDR_WIDTH-1:0]   s_axi_araddr,
    input  logic                                    s_axi_arvalid,
    output logic                                    s_axi_arready,
    // Request VC to the CPU
    output logic [eci_rd_pkg::ECI_WORD_WIDTH-1:0]   req_vc_data,
    output logic [eci_rd_pkg::ECI_SIZE_WIDTH-1:0]   req_vc_size,
    output logic                                    req_vc_valid,
    input  logic                                    req_vc_ready,
    // Response VC from the CPU
    input  logic [eci_rd_pkg::ECI_WORD_WIDTH-1:0]   rsp_vc_data,
    input  logic [eci_rd_pkg::ECI_SIZE_WIDTH-1:0]   rsp_vc_size,
    input  logic                                    rsp_vc_valid,
    output logic                                    rsp_vc_ready,
    // AXI read data channel
    output logic [eci_rd_pkg::ECI_ID_WIDTH-1:0]     m_axi_rid,
    output logic [eci_rd_pkg::ECI_WORD_WIDTH-1:0]   m_axi_rdata,
    output eci_rd_pkg::axi_resp_t                   m_axi_rresp,
    output logic                                    m_axi_rlast,
    output logic                                    m_axi_rvalid,
    input  logic                                    m_axi_rready
);

    // AR to RLDT
    axi_eci_rd_req axi_eci_rd_req_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_axi_arid    (s_axi_arid),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .req_vc_data   (req_vc_data),
        .req_vc_size   (req_vc_size),
        .req_vc_valid  (req_vc_valid),
        .req_vc_ready  (req_vc_ready)
    );

    // PSHA or NACK to R burst
    axi_eci_rd_rsp axi_eci_rd_rsp_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .rsp_vc_data   (rsp_vc_data),
        .rsp_vc_size   (rsp_vc_size),
        .rsp_vc_valid  (rsp_vc_valid),
        .rsp_vc_ready  (rsp_vc_ready),
        .m_axi_rid     (m_axi_rid),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rresp   (m_axi_rresp),
        .m_axi_rlast   (m_axi_rlast),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready)
    );

endmodule

`default_nettype wire

// ==== testbench/axi_eci_rd_bridge_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_eci_rd_bridge_chk (
    input  logic                                    aclk,
    input  logic                                    aresetn,
    input  logic [eci_rd_pkg::ECI_WORD_WIDTH-1:0]   req_vc_data,
    input  logic                                    req_vc_valid,
    input  logic                                    req_vc_ready,
    input  logic [eci_rd_pkg::ECI_ID_WIDTH-1:0]     m_axi_rid,
    input  logic [eci_rd_pkg::ECI_WORD_WIDTH-1:0]   m_axi_rdata,
    input  eci_rd_pkg::axi_resp_t                   m_axi_rresp,
    input  logic                                    m_axi_rlast,
    input  logic                                    m_axi_rvalid,
    input  logic                                    m_axi_rready
);

    // Read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    // Request word may not move while the channel is stalled
    property req_held_p;
        @(posedge aclk) disable iff (!aresetn)
        (req_vc_valid && !req_vc_ready) |=> (req_vc_valid && $stable(req_vc_data));
    endproperty

    // Same rule for the R beat, all fields together
    property r_beat_held_p;
        @(posedge aclk) disable iff (!aresetn)
        (m_axi_rvalid && !m_axi_rready) |=>
            (m_axi_rvalid && $stable(m_axi_rdata) && $stable(m_axi_rresp) &&
             $stable(m_axi_rid) && $stable(m_axi_rlast));
    endproperty

    property rlast_with_valid_p;
        @(posedge aclk) disable iff (!aresetn)
        m_axi_rlast |-> m_axi_rvalid;
    endproperty

    req_held_a: assert property (req_held_p) else begin
        fail_count++;
        $error("request word changed while req_vc_ready was low");
    end

    r_beat_held_a: assert property (r_beat_held_p) else begin
        fail_count++;
        $error("R beat changed while m_axi_rready was low");
    end

    rlast_with_valid_a: assert property (rlast_with_valid_p) else begin
        fail_count++;
        $error("m_axi_rlast high without m_axi_rvalid");
    end

endmodule

bind axi_eci_rd_bridge axi_eci_rd_bridge_chk axi_eci_rd_bridge_chk_i (.*);

`default_nettype wire

// ==== testbench/axi_eci_rd_bridge_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_eci_rd_bridge_tb;

    import eci_rd_pkg::*;

    localparam int NUM_ROWS    = 8;
    localparam int TIMEOUT     = 200;
    localparam int HOLD_CYCLES = 4;
    localparam int LINE_WORDS  = 16;

    typedef struct {
        string                      name;
        logic [ECI_ID_WIDTH-1:0]    id;
        logic [ECI_ADDR_WIDTH-1:0]  addr;
        eci_opcode_t                kind;
        bit                         hold;
        bit                         drop;
    } test_row_t;

    // Expected request word and the cycle its AR was taken
    typedef struct {
        eci_rldt_t  word;
        int         accept_cycle;
        int         stall_mark;
        int         row;
    } exp_req_t;

    typedef struct {
        int                         row;
        logic [ECI_ID_WIDTH-1:0]    id;
    } pend_rsp_t;

    logic                           aclk;
    logic                           aresetn;
    logic [ECI_ID_WIDTH-1:0]        s_axi_arid;
    logic [ECI_ADDR_WIDTH-1:0]      s_axi_araddr;
    logic                           s_axi_arvalid;
    logic                           s_axi_arready;
    logic [ECI_WORD_WIDTH-1:0]      req_vc_data;
    logic [ECI_SIZE_WIDTH-1:0]      req_vc_size;
    logic                           req_vc_valid;
    logic                           req_vc_ready;
    logic [ECI_WORD_WIDTH-1:0]      rsp_vc_data;
    logic [ECI_SIZE_WIDTH-1:0]      rsp_vc_size;
    logic                           rsp_vc_valid;
    logic                           rsp_vc_ready;
    logic [ECI_ID_WIDTH-1:0]        m_axi_rid;
    logic [ECI_WORD_WIDTH-1:0]      m_axi_rdata;
    axi_resp_t                      m_axi_rresp;
    logic                           m_axi_rlast;
    logic                           m_axi_rvalid;
    logic                           m_axi_rready;

    test_row_t                      rows [NUM_ROWS];
    exp_req_t                       exp_req_q [$];
    pend_rsp_t                      rsp_q [$];
    logic [ECI_WORD_WIDTH-1:0]      beat_data_q [$];
    int                             errors = 0;
    int                             cycle = 0;
    int                             stall_total = 0;
    int                             req_seen = 0;
    logic [31:0]                    lcg_state = 32'hf9e9_68f3;

    axi_eci_rd_bridge axi_eci_rd_bridge_i (.*);

    always #5 aclk = ~aclk;

    // Counted on the falling edge so it is stable at every rising edge
    always @(negedge aclk) cycle <= cycle + 1;

    // Every request word taken off the channel
    always @(posedge aclk) begin
        if (aresetn && req_vc_valid && req_vc_ready) begin
            req_seen <= req_seen + 1;
        end
    end

    task automatic load_table();
        rows[0] = '{"psha_basic", 5'h01, 40'h00_1234_5678, ECI_CMD_VRSP_PSHA, 1'b0, 1'b0};
        rows[1] = '{"nack_basic", 5'h02, 40'h00_0000_0080, ECI_CMD_VRSP_NACK, 1'b0, 1'b0};
        rows[2] = '{"psha_drop", 5'h1f, 40'ha5_5a3c_f0e1, ECI_CMD_VRSP_PSHA, 1'b0, 1'b1};
        rows[3] = '{"psha_hold", 5'h0a, 40'h12_3456_789a, ECI_CMD_VRSP_PSHA, 1'b1, 1'b0};
        rows[4] = '{"nack_drop", 5'h15, 40'h00_001f_c000, ECI_CMD_VRSP_NACK, 1'b0, 1'b1};
        rows[5] = '{"psha_hold_drop", 5'h03, 40'h7f_ffff_ffff, ECI_CMD_VRSP_PSHA, 1'b1, 1'b1};
        rows[6] = '{"psha_zero", 5'h00, 40'h00_0000_0000, ECI_CMD_VRSP_PSHA, 1'b0, 1'b0};
        rows[7] = '{"nack_hold", 5'h1e, 40'h80_0020_4000, ECI_CMD_VRSP_NACK, 1'b1, 1'b0};
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Line index 13..7 folded with 20..14, offset cleared
    function automatic eci_rldt_t expected_rldt(input logic [4:0] id, input logic [39:0] addr);
        eci_rldt_t   w;
        logic [39:0] a;

        a = addr;
        for (int b = 0; b < 7; b++) begin
            a[7 + b] = addr[7 + b] ^ addr[14 + b];
        end
        a[6:0]    = 7'h00;
        w         = '0;
        w.opcode  = ECI_CMD_MREQ_RLDT;
        w.rreq_id = id;
        w.dmask   = 4'hf;
        w.ns      = 1'b1;
        w.address = a;
        return w;
    endfunction

    task automatic end_run();
        int unsigned asserts;

        asserts = axi_eci_rd_bridge_i.axi_eci_rd_bridge_chk_i.fail_count;
        $display("errors: %0d check, %0d assertion", errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("ERROR: timed out waiting for %s", what);
        end_run();
    endtask

    task automatic check_req(input string name, input eci_rldt_t exp_w, input eci_rldt_t act_w);
        if (act_w !== exp_w) begin
            errors++;
            $display("mismatch %s request word expected %h actual %h", name, exp_w, act_w);
        end
    endtask

    task automatic check_size(input string name, input logic [ECI_SIZE_WIDTH-1:0] exp_s,
                              input logic [ECI_SIZE_WIDTH-1:0] act_s);
        if (act_s !== exp_s) begin
            errors++;
            $display("mismatch %s request size expected %0d actual %0d", name, exp_s, act_s);
        end
    endtask

    task automatic check_latency(input string name, input int exp_l, input int act_l);
        if (act_l != exp_l) begin
            errors++;
            $display("mismatch %s request latency expected %0d actual %0d", name, exp_l, act_l);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_f, input logic act_f);
        if (act_f !== exp_f) begin
            errors++;
            $display("mismatch %s expected %b actual %b", name, exp_f, act_f);
        end
    endtask

    task automatic check_beat(input string name, input int beat,
                              input logic [63:0] exp_d, input logic [63:0] act_d,
                              input axi_resp_t exp_r, input axi_resp_t act_r,
                              input logic [4:0] exp_id, input logic [4:0] act_id,
                              input logic exp_l, input logic act_l);
        if (act_d !== exp_d || act_r !== exp_r || act_id !== exp_id || act_l !== exp_l) begin
            errors++;
            $write("mismatch %s beat %0d expected data %h resp %h id %h last %b",
                   name, beat, exp_d, exp_r, exp_id, exp_l);
            $display(" actual data %h resp %h id %h last %b", act_d, act_r, act_id, act_l);
        end
    endtask

    task automatic wait_ar_accept(input int idx);
        int       waited;
        exp_req_t e;

        waited = 0;
        @(posedge aclk);
        while (!s_axi_arready) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                report_timeout({rows[idx].name, " AR handshake"});
            end
            @(posedge aclk);
        end
        e.word         = expected_rldt(rows[idx].id, rows[idx].addr);
        e.accept_cycle = cycle;
        e.stall_mark   = stall_total;
        e.row          = idx;
        exp_req_q.push_back(e);
    endtask

    // Stall the request VC; arready must follow it low
    task automatic hold_req_channel(input string name);
        @(negedge aclk);
        s_axi_arvalid = 1'b0;
        req_vc_ready  = 1'b0;
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            stall_total = stall_total + 1;
            @(posedge aclk);
            check_flag({name, " arready during stall"}, 1'b0, s_axi_arready);
            @(negedge aclk);
        end
        req_vc_ready = 1'b1;
    endtask

    task automatic collect_request(input int n);
        int        waited;
        exp_req_t  e;
        eci_rldt_t act_w;
        pend_rsp_t p;

        waited = 0;
        @(posedge aclk);
        while (!(req_vc_valid && req_vc_ready)) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                report_timeout("request word");
            end
            @(posedge aclk);
        end
        act_w = eci_rldt_t'(req_vc_data);
        if (exp_req_q.size() == 0) begin
            errors++;
            $display("ERROR: request word %0d arrived with no AR outstanding", n);
        end else begin
            e = exp_req_q.pop_front();
            check_req(rows[e.row].name, e.word, act_w);
            check_size(rows[e.row].name, 5'd1, req_vc_size);
            // Cycles with the channel stalled do not count
            check_latency(rows[e.row].name, 2,
                          cycle - e.accept_cycle - (stall_total - e.stall_mark));
            p.row = e.row;
            p.id  = act_w.rreq_id;
            rsp_q.push_back(p);
        end
    endtask

    task automatic send_word(input logic [63:0] word, input logic [4:0] size);
        int waited;

        rsp_vc_valid = 1'b1;
        rsp_vc_data  = word;
        rsp_vc_size  = size;
        waited = 0;
        @(posedge aclk);
        while (!rsp_vc_ready) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                report_timeout("rsp_vc_ready");
            end
            @(posedge aclk);
        end
        @(negedge aclk);
        rsp_vc_valid = 1'b0;
    endtask

    // CPU side: answer each request in order
    task automatic serve_response();
        int          waited;
        pend_rsp_t   p;
        eci_rldt_t   hdr;
        logic [63:0] word;

        waited = 0;
        while (rsp_q.size() == 0) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                report_timeout("a request to answer");
            end
            @(negedge aclk);
        end
        p           = rsp_q.pop_front();
        hdr         = '0;
        hdr.opcode  = rows[p.row].kind;
        hdr.rreq_id = p.id;
        if (rows[p.row].kind == ECI_CMD_VRSP_PSHA) begin
            send_word(hdr, 5'd17);
            for (int w = 0; w < LINE_WORDS; w++) begin
                word = {next_random(), next_random()};
                beat_data_q.push_back(word);
                send_word(word, 5'd17);
            end
        end else begin
            send_word(hdr, 5'd1);
        end
    endtask

    task automatic wait_r_beat(input bit drop, input string name,
                               output logic [63:0] data, output axi_resp_t resp,
                               output logic [4:0] id, output logic last);
        int waited;

        waited = 0;
        @(negedge aclk);
        m_axi_rready = drop ? !m_axi_rready : 1'b1;
        @(posedge aclk);
        while (!(m_axi_rvalid && m_axi_rready)) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                report_timeout({name, " R beat"});
            end
            @(negedge aclk);
            m_axi_rready = drop ? !m_axi_rready : 1'b1;
            @(posedge aclk);
        end
        data = m_axi_rdata;
        resp = m_axi_rresp;
        id   = m_axi_rid;
        last = m_axi_rlast;
    endtask

    task automatic collect_burst(input int n);
        logic [63:0] act_d;
        logic [63:0] exp_d;
        axi_resp_t   act_r;
        axi_resp_t   exp_r;
        logic [4:0]  act_id;
        logic        act_l;

        for (int b = 0; b < LINE_WORDS; b++) begin
            wait_r_beat(rows[n].drop, rows[n].name, act_d, act_r, act_id, act_l);
            exp_d = '0;
            exp_r = AXI_RESP_SLVERR;
            if (rows[n].kind == ECI_CMD_VRSP_PSHA) begin
                exp_r = AXI_RESP_OKAY;
                if (beat_data_q.size() == 0) begin
                    errors++;
                    $display("ERROR: %s beat %0d has no data word behind it", rows[n].name, b);
                end else begin
                    exp_d = beat_data_q.pop_front();
                end
            end
            check_beat(rows[n].name, b, exp_d, act_d, exp_r, act_r,
                       rows[n].id, act_id, (b == LINE_WORDS - 1), act_l);
        end
    endtask

    initial begin
        load_table();
        aclk          = 1'b0;
        aresetn       = 1'b0;
        s_axi_arid    = '0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        req_vc_ready  = 1'b1;
        rsp_vc_data   = '0;
        rsp_vc_size   = '0;
        rsp_vc_valid  = 1'b0;
        m_axi_rready  = 1'b1;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(posedge aclk);
        check_flag("reset req_vc_valid", 1'b0, req_vc_valid);
        check_flag("reset m_axi_rvalid", 1'b0, m_axi_rvalid);
        check_flag("reset rsp_vc_ready", 1'b1, rsp_vc_ready);
        @(negedge aclk);
        fork
            begin : ar_driver
                // ARs go back to back unless a row stalls the channel
                for (int i = 0; i < NUM_ROWS; i++) begin
                    @(negedge aclk);
                    s_axi_arvalid = 1'b1;
                    s_axi_arid    = rows[i].id;
                    s_axi_araddr  = rows[i].addr;
                    wait_ar_accept(i);
                    if (rows[i].hold) begin
                        hold_req_channel(rows[i].name);
                    end
                end
                @(negedge aclk);
                s_axi_arvalid = 1'b0;
            end
            begin : req_monitor
                for (int n = 0; n < NUM_ROWS; n++) begin
                    collect_request(n);
                end
            end
            begin : cpu_model
                for (int n = 0; n < NUM_ROWS; n++) begin
                    serve_response();
                end
            end
            begin : r_monitor
                for (int n = 0; n < NUM_ROWS; n++) begin
                    collect_burst(n);
                end
            end
        join
        repeat (4) @(posedge aclk);
        check_flag("idle req_vc_valid", 1'b0, req_vc_valid);
        check_flag("idle m_axi_rvalid", 1'b0, m_axi_rvalid);
        if (req_seen != NUM_ROWS) begin
            errors++;
            $display("ERROR: %0d request words left the bridge for %0d ARs", req_seen, NUM_ROWS);
        end
        if (exp_req_q.size() != 0 || beat_data_q.size() != 0) begin
            errors++;
            $display("ERROR: requests or data words left over at the end");
        end
        end_run();
    end

endmodule

`default_nettype wire

// ==== axi_eci_rd_bridge.f ====
logic/eci_rd_pkg.sv
logic/axi_eci_rd_req.sv
logic/axi_eci_rd_rsp.sv
logic/axi_eci_rd_bridge.sv
testbench/axi_eci_rd_bridge_chk.sv
testbench/axi_eci_rd_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: axi_eci_rd_bridge

dependencies: {}

sources:
  # Package first, then the two paths and the top level
  - logic/eci_rd_pkg.sv
  - logic/axi_eci_rd_req.sv
  - logic/axi_eci_rd_rsp.sv
  - logic/axi_eci_rd_bridge.sv

  - target: test
    files:
      - testbench/axi_eci_rd_bridge_chk.sv
      - testbench/axi_eci_rd_bridge_tb.sv
